//--- hw/can_defines.svh
/* CAN controller parameters
   Mailbox count, serial frame length and register offsets */
`ifndef CAN_DEFINES_SVH
`define CAN_DEFINES_SVH

`define CAN_NUM_MAILBOXES 4
// Start bit + 11 id + 4 len + 64 data
`define CAN_FRAME_BITS 80

`define CAN_MBOX_BASE 8'h40
`define CAN_MBOX_STRIDE 8'h10

`define CAN_REG_STATUS 8'h00
`define CAN_REG_RX_IDLEN 8'h10
`define CAN_REG_RX_DLO 8'h14
`define CAN_REG_RX_DHI 8'h18

`endif

//--- hw/can_pkg.sv
/* CAN controller types
   Frame layout, mailbox write strobe and FSM state encodings */
`include "can_defines.svh"

package can_pkg;

  // Packed so that bit 78 is the first bit on the wire after the start bit
  typedef struct packed {
    logic [10:0] id;
    logic [3:0] len;
    logic [63:0] data;
  } can_frame_t;

  // Encoding follows address bits 3:2 within a mailbox
  typedef enum logic [1:0] {
    FIELD_ID_LEN = 2'd0,
    FIELD_DATA_LO = 2'd1,
    FIELD_DATA_HI = 2'd2,
    FIELD_REQUEST = 2'd3
  } mbox_field_e;

  typedef struct packed {
    logic [`CAN_NUM_MAILBOXES-1:0] en;
    mbox_field_e field;
    logic [31:0] wdata;
  } mbox_write_t;

  typedef enum logic [1:0] {AXI_IDLE, AXI_WRITE, AXI_READ, AXI_RESP} axi_state_e;

  typedef enum logic {TX_IDLE, TX_SHIFT} tx_state_e;

  typedef enum logic [1:0] {RX_IDLE, RX_SHIFT, RX_DONE} rx_state_e;

endpackage

//--- hw/can_axi_regs.sv
/* AXI4-Lite register block
   Decodes mailbox writes, returns status and holds the received frame */
`timescale 1ns/1ps
`include "can_defines.svh"

module can_axi_regs (
  input logic s_axi_aclk,
  input logic s_axi_aresetn,
  input logic [31:0] s_axi_awaddr,
  input logic s_axi_awvalid,
  output logic s_axi_awready,
  input logic [31:0] s_axi_wdata,
  input logic [3:0] s_axi_wstrb,
  input logic s_axi_wvalid,
  output logic s_axi_wready,
  output logic [1:0] s_axi_bresp,
  output logic s_axi_bvalid,
  input logic s_axi_bready,
  input logic [31:0] s_axi_araddr,
  input logic s_axi_arvalid,
  output logic s_axi_arready,
  output logic [31:0] s_axi_rdata,
  output logic [1:0] s_axi_rresp,
  output logic s_axi_rvalid,
  input logic s_axi_rready,
  output can_pkg::mbox_write_t mbox_wr,
  input can_pkg::can_frame_t [`CAN_NUM_MAILBOXES-1:0] mbox_frame,
  input logic [`CAN_NUM_MAILBOXES-1:0] mbox_pending,
  input logic tx_busy,
  input can_pkg::can_frame_t rx_frame,
  input logic rx_done
);

  can_pkg::axi_state_e state;
  logic [7:0] wr_addr;
  logic [7:0] rd_addr;
  logic [31:0] rd_data;
  logic wr_fire;
  logic rx_ready;
  can_pkg::can_frame_t rx_frame_q;

  function automatic logic mbox_hit(input logic [7:0] addr, input int k);
    int lo;
    lo = `CAN_MBOX_BASE + k * `CAN_MBOX_STRIDE;
    return (int'(addr) >= lo) && (int'(addr) < lo + `CAN_MBOX_STRIDE);
  endfunction

  // Every response is OKAY; s_axi_wstrb is not decoded, writes are whole words
  assign s_axi_bresp = 2'b00;
  assign s_axi_rresp = 2'b00;

  assign wr_fire = (state == can_pkg::AXI_WRITE) && s_axi_wvalid && s_axi_wready;

  // Mailbox strobe lands on the same edge that raises bvalid
  always_comb begin
    mbox_wr.en = '0;
    mbox_wr.field = can_pkg::mbox_field_e'(wr_addr[3:2]);
    mbox_wr.wdata = s_axi_wdata;
    for (int k = 0; k < `CAN_NUM_MAILBOXES; k++) begin
      if (wr_fire && mbox_hit(wr_addr, k))
        mbox_wr.en[k] = 1'b1;
    end
  end

  always_comb begin
    rd_data = '0;
    case (rd_addr)
      `CAN_REG_STATUS: rd_data = {30'b0, rx_ready, tx_busy};
      `CAN_REG_RX_IDLEN: rd_data = {16'b0, rx_frame_q.len, 1'b0, rx_frame_q.id};
      `CAN_REG_RX_DLO: rd_data = rx_frame_q.data[31:0];
      `CAN_REG_RX_DHI: rd_data = rx_frame_q.data[63:32];
      default: begin
        for (int k = 0; k < `CAN_NUM_MAILBOXES; k++) begin
          if (mbox_hit(rd_addr, k)) begin
            case (can_pkg::mbox_field_e'(rd_addr[3:2]))
              can_pkg::FIELD_ID_LEN:
                rd_data = {16'b0, mbox_frame[k].len, 1'b0, mbox_frame[k].id};
              can_pkg::FIELD_DATA_LO: rd_data = mbox_frame[k].data[31:0];
              can_pkg::FIELD_DATA_HI: rd_data = mbox_frame[k].data[63:32];
              default: rd_data = {31'b0, mbox_pending[k]};
            endcase
          end
        end
      end
    endcase
  end

  always_ff @(posedge s_axi_aclk) begin
    if (!s_axi_aresetn) begin
      state <= can_pkg::AXI_IDLE;
      s_axi_awready <= 1'b0;
      s_axi_wready <= 1'b0;
      s_axi_bvalid <= 1'b0;
      s_axi_arready <= 1'b0;
      s_axi_rvalid <= 1'b0;
    end else begin
      case (state)
        can_pkg::AXI_IDLE: begin
          // Write wins when both address channels are valid
          if (s_axi_awvalid) begin
            s_axi_awready <= 1'b1;
            s_axi_wready <= 1'b1;
            wr_addr <= s_axi_awaddr[7:0];
            state <= can_pkg::AXI_WRITE;
          end else if (s_axi_arvalid) begin
            s_axi_arready <= 1'b1;
            rd_addr <= s_axi_araddr[7:0];
            state <= can_pkg::AXI_READ;
          end
        end
        can_pkg::AXI_WRITE: begin
          s_axi_awready <= 1'b0;
          if (wr_fire) begin
            s_axi_wready <= 1'b0;
            s_axi_bvalid <= 1'b1;
            state <= can_pkg::AXI_RESP;
          end
        end
        can_pkg::AXI_READ: begin
          s_axi_arready <= 1'b0;
          s_axi_rvalid <= 1'b1;
          s_axi_rdata <= rd_data;
          state <= can_pkg::AXI_RESP;
        end
        default: begin
          if (s_axi_bvalid && s_axi_bready) begin
            s_axi_bvalid <= 1'b0;
            state <= can_pkg::AXI_IDLE;
          end else if (s_axi_rvalid && s_axi_rready) begin
            s_axi_rvalid <= 1'b0;
            state <= can_pkg::AXI_IDLE;
          end
        end
      endcase
    end
  end

  // Sticky flag, a new frame takes precedence over the clearing read
  always_ff @(posedge s_axi_aclk) begin
    if (!s_axi_aresetn) begin
      rx_ready <= 1'b0;
    end else if (rx_done) begin
      rx_ready <= 1'b1;
    end else if (state == can_pkg::AXI_READ && rd_addr == `CAN_REG_RX_DHI) begin
      rx_ready <= 1'b0;
    end
  end

  always_ff @(posedge s_axi_aclk) begin
    if (rx_done)
      rx_frame_q <= rx_frame;
  end

  a_one_response: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
    !(s_axi_bvalid && s_axi_rvalid));

endmodule

//--- hw/can_tx_mailbox.sv
/* Transmit mailbox
   Holds one frame and its pending flag until the engine grants it */
`timescale 1ns/1ps

module can_tx_mailbox (
  input logic s_axi_aclk,
  input logic s_axi_aresetn,
  input logic wr_en,
  input can_pkg::mbox_field_e wr_field,
  input logic [31:0] wdata,
  input logic grant,
  output can_pkg::can_frame_t frame,
  output logic pending
);

  // Frame contents are locked while a transmission is pending
  always_ff @(posedge s_axi_aclk) begin
    if (wr_en && !pending) begin
      case (wr_field)
        can_pkg::FIELD_ID_LEN: begin
          frame.id <= wdata[10:0];
          frame.len <= wdata[15:12];
        end
        can_pkg::FIELD_DATA_LO: frame.data[31:0] <= wdata;
        can_pkg::FIELD_DATA_HI: frame.data[63:32] <= wdata;
        default: ;
      endcase
    end
  end

  always_ff @(posedge s_axi_aclk) begin
    if (!s_axi_aresetn) begin
      pending <= 1'b0;
    end else if (grant) begin
      pending <= 1'b0;
    end else if (wr_en && wr_field == can_pkg::FIELD_REQUEST && wdata[0]) begin
      pending <= 1'b1;
    end
  end

  a_grant_pending: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
    grant |-> pending);

endmodule

//--- hw/can_tx_engine.sv
/* Transmit engine
   Grants the pending mailbox with the lowest id and shifts its frame onto tx */
`timescale 1ns/1ps
`include "can_defines.svh"

module can_tx_engine (
  input logic s_axi_aclk,
  input logic s_axi_aresetn,
  input can_pkg::can_frame_t [`CAN_NUM_MAILBOXES-1:0] mbox_frame,
  input logic [`CAN_NUM_MAILBOXES-1:0] mbox_pending,
  output logic [`CAN_NUM_MAILBOXES-1:0] grant,
  output logic tx,
  output logic tx_busy
);

  localparam int CNT_W = $clog2(`CAN_FRAME_BITS);

  can_pkg::tx_state_e state;
  logic [`CAN_FRAME_BITS-2:0] shift_q;
  logic [CNT_W-1:0] bit_cnt;
  logic [`CAN_NUM_MAILBOXES-1:0] pick;
  logic [10:0] best_id;
  logic found;
  can_pkg::can_frame_t sel_frame;

  // Lowest id wins, strict compare keeps the lower index on a tie
  always_comb begin
    pick = '0;
    best_id = '1;
    found = 1'b0;
    sel_frame = mbox_frame[0];
    for (int k = 0; k < `CAN_NUM_MAILBOXES; k++) begin
      if (mbox_pending[k] && (!found || mbox_frame[k].id < best_id)) begin
        pick = '0;
        pick[k] = 1'b1;
        best_id = mbox_frame[k].id;
        sel_frame = mbox_frame[k];
        found = 1'b1;
      end
    end
  end

  assign grant = (state == can_pkg::TX_IDLE) ? pick : '0;

  always_ff @(posedge s_axi_aclk) begin
    if (!s_axi_aresetn) begin
      state <= can_pkg::TX_IDLE;
      tx <= 1'b1;
      tx_busy <= 1'b0;
      bit_cnt <= '0;
    end else begin
      case (state)
        can_pkg::TX_IDLE: begin
          if (found) begin
            // Start bit goes out on the next cycle
            shift_q <= sel_frame;
            tx <= 1'b0;
            tx_busy <= 1'b1;
            bit_cnt <= '0;
            state <= can_pkg::TX_SHIFT;
          end
        end
        default: begin
          if (bit_cnt == CNT_W'(`CAN_FRAME_BITS - 1)) begin
            tx <= 1'b1;
            tx_busy <= 1'b0;
            state <= can_pkg::TX_IDLE;
          end else begin
            tx <= shift_q[`CAN_FRAME_BITS-2];
            shift_q <= shift_q << 1;
            bit_cnt <= bit_cnt + 1'b1;
          end
        end
      endcase
    end
  end

  a_grant_onehot: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
    $onehot0(grant));

endmodule

//--- hw/can_rx_deframer.sv
/* Receive deframer
   Waits for a start bit on rx and shifts in one 79-bit frame */
`timescale 1ns/1ps
`include "can_defines.svh"

module can_rx_deframer (
  input logic s_axi_aclk,
  input logic s_axi_aresetn,
  input logic rx,
  output can_pkg::can_frame_t rx_frame,
  output logic rx_done
);

  localparam int CNT_W = $clog2(`CAN_FRAME_BITS);

  can_pkg::rx_state_e state;
  logic [CNT_W-1:0] bit_cnt;

  assign rx_done = (state == can_pkg::RX_DONE);

  always_ff @(posedge s_axi_aclk) begin
    if (!s_axi_aresetn) begin
      state <= can_pkg::RX_IDLE;
      bit_cnt <= '0;
    end else begin
      case (state)
        can_pkg::RX_IDLE: begin
          // Dominant bit marks start of frame
          if (!rx) begin
            bit_cnt <= '0;
            state <= can_pkg::RX_SHIFT;
          end
        end
        can_pkg::RX_SHIFT: begin
          bit_cnt <= bit_cnt + 1'b1;
          if (bit_cnt == CNT_W'(`CAN_FRAME_BITS - 2))
            state <= can_pkg::RX_DONE;
        end
        default: state <= can_pkg::RX_IDLE;
      endcase
    end
  end

  // MSB first, so new bits enter at the bottom
  always_ff @(posedge s_axi_aclk) begin
    if (state == can_pkg::RX_SHIFT)
      rx_frame <= {rx_frame[`CAN_FRAME_BITS-3:0], rx};
  end

endmodule

//--- hw/can_controller_top.sv
/* CAN controller top
   AXI4-Lite registers, transmit mailboxes, transmit engine and receiver */
`timescale 1ns/1ps
`include "can_defines.svh"

module can_controller_top (
  input logic s_axi_aclk,
  input logic s_axi_aresetn,
  input logic [31:0] s_axi_awaddr,
  input logic s_axi_awvalid,
  output logic s_axi_awready,
  input logic [31:0] s_axi_wdata,
  input logic [3:0] s_axi_wstrb,
  input logic s_axi_wvalid,
  output logic s_axi_wready,
  output logic [1:0] s_axi_bresp,
  output logic s_axi_bvalid,
  input logic s_axi_bready,
  input logic [31:0] s_axi_araddr,
  input logic s_axi_arvalid,
  output logic s_axi_arready,
  output logic [31:0] s_axi_rdata,
  output logic [1:0] s_axi_rresp,
  output logic s_axi_rvalid,
  input logic s_axi_rready,
  input logic rx,
  output logic tx
);

  can_pkg::mbox_write_t mbox_wr;
  can_pkg::can_frame_t [`CAN_NUM_MAILBOXES-1:0] mbox_frame;
  logic [`CAN_NUM_MAILBOXES-1:0] mbox_pending;
  logic [`CAN_NUM_MAILBOXES-1:0] grant;
  logic tx_busy;
  can_pkg::can_frame_t rx_frame;
  logic rx_done;

  can_axi_regs can_axi_regs_inst (
    .s_axi_aclk(s_axi_aclk),
    .s_axi_aresetn(s_axi_aresetn),
    .s_axi_awaddr(s_axi_awaddr),
    .s_axi_awvalid(s_axi_awvalid),
    .s_axi_awready(s_axi_awready),
    .s_axi_wdata(s_axi_wdata),
    .s_axi_wstrb(s_axi_wstrb),
    .s_axi_wvalid(s_axi_wvalid),
    .s_axi_wready(s_axi_wready),
    .s_axi_bresp(s_axi_bresp),
    .s_axi_bvalid(s_axi_bvalid),
    .s_axi_bready(s_axi_bready),
    .s_axi_araddr(s_axi_araddr),
    .s_axi_arvalid(s_axi_arvalid),
    .s_axi_arready(s_axi_arready),
    .s_axi_rdata(s_axi_rdata),
    .s_axi_rresp(s_axi_rresp),
    .s_axi_rvalid(s_axi_rvalid),
    .s_axi_rready(s_axi_rready),
    .mbox_wr(mbox_wr),
    .mbox_frame(mbox_frame),
    .mbox_pending(mbox_pending),
    .tx_busy(tx_busy),
    .rx_frame(rx_frame),
    .rx_done(rx_done)
  );

  for (genvar k = 0; k < `CAN_NUM_MAILBOXES; k++) begin : g_mbox
    can_tx_mailbox can_tx_mailbox_inst (
      .s_axi_aclk(s_axi_aclk),
      .s_axi_aresetn(s_axi_aresetn),
      .wr_en(mbox_wr.en[k]),
      .wr_field(mbox_wr.field),
      .wdata(mbox_wr.wdata),
      .grant(grant[k]),
      .frame(mbox_frame[k]),
      .pending(mbox_pending[k])
    );
  end

  can_tx_engine can_tx_engine_inst (
    .s_axi_aclk(s_axi_aclk),
    .s_axi_aresetn(s_axi_aresetn),
    .mbox_frame(mbox_frame),
    .mbox_pending(mbox_pending),
    .grant(grant),
    .tx(tx),
    .tx_busy(tx_busy)
  );

  can_rx_deframer can_rx_deframer_inst (
    .s_axi_aclk(s_axi_aclk),
    .s_axi_aresetn(s_axi_aresetn),
    .rx(rx),
    .rx_frame(rx_frame),
    .rx_done(rx_done)
  );

endmodule

//--- bench/can_controller_tb.sv
/* CAN controller testbench
   AXI register traffic with tx looped back to rx, checked by assertions */
`timescale 1ns/1ps
`include "can_defines.svh"

module can_controller_tb;

  localparam int WAIT_LIMIT = 400;
  localparam int FRAME_LIMIT = 1000;
  localparam int NUM = `CAN_NUM_MAILBOXES;

  logic s_axi_aclk;
  logic s_axi_aresetn;
  logic [31:0] s_axi_awaddr;
  logic s_axi_awvalid;
  logic s_axi_awready;
  logic [31:0] s_axi_wdata;
  logic [3:0] s_axi_wstrb;
  logic s_axi_wvalid;
  logic s_axi_wready;
  logic [1:0] s_axi_bresp;
  logic s_axi_bvalid;
  logic s_axi_bready;
  logic [31:0] s_axi_araddr;
  logic s_axi_arvalid;
  logic s_axi_arready;
  logic [31:0] s_axi_rdata;
  logic [1:0] s_axi_rresp;
  logic s_axi_rvalid;
  logic s_axi_rready;
  logic rx;
  logic tx;

  int checks = 0;
  int value_errors = 0;
  int protocol_errors = 0;
  integer seed;
  logic [79:0] tx_frames [$];
  logic [79:0] cap_bits;
  int cap_count = 0;

  can_controller_top can_controller_top_inst (.*);

  // Loopback
  assign rx = tx;

  initial begin
    s_axi_aclk = 1'b0;
    forever #20 s_axi_aclk = ~s_axi_aclk;
  end

  // Start bit, then id, len and data, each MSB first
  function automatic logic [79:0] expected_bits(input logic [10:0] id, input logic [3:0] len,
                                                input logic [63:0] data);
    return {1'b0, id, len, data};
  endfunction

  function automatic logic [31:0] idlen_word(input logic [10:0] id, input logic [3:0] len);
    return {16'b0, len, 1'b0, id};
  endfunction

  function automatic logic [31:0] mbox_addr(input int k, input int offset);
    return `CAN_MBOX_BASE + k * `CAN_MBOX_STRIDE + offset;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    assert (actual === expected) else begin
      value_errors++;
      $display("ERROR %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_frame(input string name, input logic [79:0] expected,
                             input logic [79:0] actual);
    checks++;
    assert (actual === expected) else begin
      value_errors++;
      $display("ERROR %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic wait_failed(input string what);
    $display("Timeout: the DUT never gave %s", what);
    $display("Checks: %0d, value errors: %0d, protocol errors: %0d",
             checks, value_errors, protocol_errors);
    $display("Test failures found");
    $finish;
  endtask

  task automatic axi_write(input logic [31:0] addr, input logic [31:0] data, input int hold);
    int t;
    @(posedge s_axi_aclk);
    #2;
    s_axi_awaddr = addr;
    s_axi_awvalid = 1'b1;
    s_axi_wdata = data;
    s_axi_wvalid = 1'b1;
    t = 0;
    while (!(s_axi_awready && s_axi_wready)) begin
      if (t == WAIT_LIMIT)
        wait_failed("awready and wready");
      @(posedge s_axi_aclk);
      #2;
      t++;
    end
    @(posedge s_axi_aclk);
    #2;
    s_axi_awvalid = 1'b0;
    s_axi_wvalid = 1'b0;
    t = 0;
    while (!s_axi_bvalid) begin
      if (t == WAIT_LIMIT)
        wait_failed("bvalid");
      @(posedge s_axi_aclk);
      #2;
      t++;
    end
    // Back-pressure on the write response
    repeat (hold) begin
      @(posedge s_axi_aclk);
      #2;
    end
    s_axi_bready = 1'b1;
    @(posedge s_axi_aclk);
    #2;
    s_axi_bready = 1'b0;
  endtask

  task automatic axi_read(input logic [31:0] addr, output logic [31:0] data, input int hold);
    int t;
    @(posedge s_axi_aclk);
    #2;
    s_axi_araddr = addr;
    s_axi_arvalid = 1'b1;
    t = 0;
    while (!s_axi_arready) begin
      if (t == WAIT_LIMIT)
        wait_failed("arready");
      @(posedge s_axi_aclk);
      #2;
      t++;
    end
    @(posedge s_axi_aclk);
    #2;
    s_axi_arvalid = 1'b0;
    t = 0;
    while (!s_axi_rvalid) begin
      if (t == WAIT_LIMIT)
        wait_failed("rvalid");
      @(posedge s_axi_aclk);
      #2;
      t++;
    end
    data = s_axi_rdata;
    repeat (hold) begin
      @(posedge s_axi_aclk);
      #2;
    end
    s_axi_rready = 1'b1;
    @(posedge s_axi_aclk);
    #2;
    s_axi_rready = 1'b0;
  endtask

  task automatic load_mailbox(input int k, input logic [10:0] id, input logic [3:0] len,
                              input logic [63:0] data);
    axi_write(mbox_addr(k, 0), idlen_word(id, len), 0);
    axi_write(mbox_addr(k, 4), data[31:0], 0);
    axi_write(mbox_addr(k, 8), data[63:32], 0);
  endtask

  task automatic wait_frames(input int n);
    int t;
    t = 0;
    while (tx_frames.size() < n) begin
      if (t == FRAME_LIMIT)
        wait_failed("the expected frames on tx");
      @(posedge s_axi_aclk);
      t++;
    end
  endtask

  // Collects each 80-bit frame seen on tx, sampled mid-cycle
  always @(negedge s_axi_aclk) begin
    if (!s_axi_aresetn) begin
      cap_count = 0;
    end else if (cap_count > 0 || tx == 1'b0) begin
      cap_bits = {cap_bits[78:0], tx};
      cap_count++;
      if (cap_count == `CAN_FRAME_BITS) begin
        tx_frames.push_back(cap_bits);
        cap_count = 0;
      end
    end
  end

  a_bvalid_held: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
    s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid)
    else begin
      protocol_errors++;
      $display("bvalid dropped before bready was given");
    end

  a_rvalid_held: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
    s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid)
    else begin
      protocol_errors++;
      $display("rvalid dropped before rready was given");
    end

  a_no_accept: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
    (s_axi_bvalid || s_axi_rvalid) |-> !(s_axi_awready || s_axi_arready))
    else begin
      protocol_errors++;
      $display("a new address was accepted while a response was still open");
    end

  a_resp_okay: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
    (s_axi_bvalid || s_axi_rvalid) |-> (s_axi_bresp == 2'b00 && s_axi_rresp == 2'b00))
    else begin
      protocol_errors++;
      $display("a response other than OKAY was returned");
    end

  initial begin
    logic [31:0] rd;
    logic [10:0] one_id;
    logic [3:0] one_len;
    logic [63:0] one_data;
    logic [10:0] ids [NUM];
    logic [3:0] lens [NUM];
    logic [63:0] datas [NUM];
    int order [NUM];
    bit taken [NUM];
    bit dup;
    int last;

    seed = 32'h5d9d;
    s_axi_aresetn = 1'b0;
    s_axi_awaddr = '0;
    s_axi_awvalid = 1'b0;
    s_axi_wdata = '0;
    s_axi_wstrb = 4'hf;
    s_axi_wvalid = 1'b0;
    s_axi_bready = 1'b0;
    s_axi_araddr = '0;
    s_axi_arvalid = 1'b0;
    s_axi_rready = 1'b0;
    repeat (16) @(posedge s_axi_aclk);
    #2;
    s_axi_aresetn = 1'b1;

    // Reset state
    check_value("reset outputs", 32'h20, {26'b0, tx, s_axi_awready, s_axi_wready,
                s_axi_bvalid, s_axi_arready, s_axi_rvalid});
    axi_read(`CAN_REG_STATUS, rd, 0);
    check_value("status after reset", 32'h0, rd);

    // Register readback and unmapped space
    one_id = 11'($random(seed));
    one_len = 4'($random(seed));
    one_data = {$random(seed), $random(seed)};
    load_mailbox(0, one_id, one_len, one_data);
    axi_read(mbox_addr(0, 0), rd, 0);
    check_value("mailbox id and len", idlen_word(one_id, one_len), rd);
    axi_read(mbox_addr(0, 4), rd, 0);
    check_value("mailbox data low", one_data[31:0], rd);
    axi_read(mbox_addr(0, 8), rd, 0);
    check_value("mailbox data high", one_data[63:32], rd);
    axi_read(mbox_addr(0, 12), rd, 0);
    check_value("mailbox idle pending", 32'h0, rd);
    axi_read(32'h30, rd, 0);
    check_value("unmapped 0x30", 32'h0, rd);
    axi_read(32'h80, rd, 0);
    check_value("unmapped 0x80", 32'h0, rd);

    // Single frame on mailbox 1
    one_id = 11'($random(seed));
    one_len = 4'($random(seed));
    one_data = {$random(seed), $random(seed)};
    load_mailbox(1, one_id, one_len, one_data);
    axi_write(mbox_addr(1, 12), 32'h1, 0);
    axi_read(`CAN_REG_STATUS, rd, 0);
    check_value("status during frame", 32'h1, rd);
    axi_read(mbox_addr(1, 12), rd, 0);
    check_value("pending after grant", 32'h0, rd);
    wait_frames(1);
    check_frame("single frame bits", expected_bits(one_id, one_len, one_data),
                tx_frames.pop_front());

    // Four mailboxes with distinct ids
    for (int k = 0; k < NUM; k++) begin
      dup = 1'b1;
      while (dup) begin
        ids[k] = 11'($random(seed));
        dup = 1'b0;
        for (int j = 0; j < k; j++)
          if (ids[j] == ids[k])
            dup = 1'b1;
      end
      lens[k] = 4'($random(seed));
      datas[k] = {$random(seed), $random(seed)};
      load_mailbox(k, ids[k], lens[k], datas[k]);
      taken[k] = 1'b0;
    end
    for (int r = 0; r < NUM; r++) begin
      order[r] = -1;
      for (int k = 0; k < NUM; k++)
        if (!taken[k] && (order[r] < 0 || ids[k] < ids[order[r]]))
          order[r] = k;
      taken[order[r]] = 1'b1;
    end
    // Lowest id starts at once, the rest are requested highest id first
    axi_write(mbox_addr(order[0], 12), 32'h1, 0);
    for (int r = NUM - 1; r > 0; r--)
      axi_write(mbox_addr(order[r], 12), 32'h1, 0);
    last = order[NUM-1];
    axi_write(mbox_addr(last, 4), ~datas[last][31:0], 0);
    wait_frames(NUM);
    for (int r = 0; r < NUM; r++)
      check_frame("arbitration order", expected_bits(ids[order[r]], lens[order[r]],
                  datas[order[r]]), tx_frames.pop_front());
    axi_read(mbox_addr(last, 4), rd, 0);
    check_value("write while pending", datas[last][31:0], rd);

    // Loopback receive registers
    axi_read(`CAN_REG_STATUS, rd, 0);
    check_value("status with rx_ready", 32'h2, rd);
    axi_read(`CAN_REG_RX_IDLEN, rd, 0);
    check_value("rx id and len", idlen_word(ids[last], lens[last]), rd);
    axi_read(`CAN_REG_RX_DLO, rd, 0);
    check_value("rx data low", datas[last][31:0], rd);
    axi_read(`CAN_REG_RX_DHI, rd, 0);
    check_value("rx data high", datas[last][63:32], rd);
    axi_read(`CAN_REG_STATUS, rd, 0);
    check_value("rx_ready cleared", 32'h0, rd);

    // Back-pressure with a second transaction already waiting
    fork
      axi_write(mbox_addr(0, 4), 32'ha5a5_0f0f, 6);
      begin
        repeat (2) @(posedge s_axi_aclk);
        axi_read(`CAN_REG_STATUS, rd, 0);
      end
    join
    check_value("read after held write", 32'h0, rd);
    fork
      axi_read(mbox_addr(0, 4), rd, 6);
      begin
        repeat (2) @(posedge s_axi_aclk);
        axi_write(mbox_addr(0, 8), 32'h1234_5678, 0);
      end
    join
    check_value("held read data", 32'ha5a5_0f0f, rd);
    axi_read(mbox_addr(0, 8), rd, 0);
    check_value("write after held read", 32'h1234_5678, rd);

    $display("Checks: %0d, value errors: %0d, protocol errors: %0d",
             checks, value_errors, protocol_errors);
    if (value_errors == 0 && protocol_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- compile.f
+incdir+hw
hw/can_pkg.sv
hw/can_axi_regs.sv
hw/can_tx_mailbox.sv
hw/can_tx_engine.sv
hw/can_rx_deframer.sv
hw/can_controller_top.sv
bench/can_controller_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the CAN controller testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f compile.f \
  --top-module can_controller_tb -o can_sim || exit 1
./obj_dir/can_sim > sim.log 2>&1 || echo "Simulator returned a non-zero status"
cat sim.log
grep -q "Test failures found" sim.log && echo "Simulation FAILED" && exit 1
grep -q "All tests passed!" sim.log && echo "Simulation PASSED" && exit 0
echo "Simulation ended without a result"
exit 1
